// ==== include/cpuCore_config.svh ====
`ifndef CPUCORE_CONFIG_SVH
`define CPUCORE_CONFIG_SVH

// Bus, register and instruction width
`define CPU_DATA_WIDTH 16

// Size of the register file
`define CPU_REG_COUNT 8

// Bit positions in the four-bit flag word
`define FLAGS_C 0
`define FLAGS_Z 1
`define FLAGS_N 2
`define FLAGS_V 3

// First fetch address after reset
`define RESET_PC 16'h0000

`endif

// ==== verilog/opcodes.sv ====
`include "cpuCore_config.svh"

package opcodes;

   typedef logic [`CPU_DATA_WIDTH-1:0] word_t;

   // Instruction codes, IR bits 15:11
   typedef enum logic [4:0] {
      ADD      = 5'h00,
      ADDI     = 5'h01,
      ADDIB    = 5'h02,
      ADC      = 5'h03,
      ADCI     = 5'h04,
      SUB      = 5'h05,
      SUBI     = 5'h06,
      SUBIB    = 5'h07,
      SUC      = 5'h08,
      SUCI     = 5'h09,
      CMP      = 5'h0A,
      CMPI     = 5'h0B,
      LUI      = 5'h0C,
      LLI      = 5'h0D,
      LDW      = 5'h0E,
      STW      = 5'h0F,
      BR       = 5'h10,   // Branch and stack codes decode as no-ops
      BNE      = 5'h11,
      BE       = 5'h12,
      BLT      = 5'h13,
      BGE      = 5'h14,
      BWL      = 5'h15,
      JMP      = 5'h16,
      RET      = 5'h17,
      PUSH_POP = 5'h18
   } Opcode_t;

   typedef enum logic [2:0] {
      FnNOP,
      FnADD,
      FnADC,
      FnSUB,
      FnSBC,   // Subtract with borrow, carry set means no borrow
      FnA,     // Pass operand 1
      FnB      // Pass operand 2
   } alu_functions_t;

   typedef enum logic {Op1Rd1} Op1_select_t;

   typedef enum logic {Op2Rd2, Op2Imm} Op2_select_t;

   typedef enum logic [1:0] {ImmShort, ImmLong, ImmUpper} Imm_select_t;

   typedef enum logic {WdAlu, WdSys} Wd_select_t;

   typedef enum logic [1:0] {Pc1, PcAlu, PcLr} pc_select_t;

   typedef enum logic {LrSys} Lr_select_t;

   typedef enum logic {Rs1Ra, Rs1Rd} Rs1_select_t;

endpackage

// ==== verilog/ctrlBus.sv ====
`timescale 1ns/1ps

interface ctrlBus;
   opcodes::alu_functions_t AluOp;
   opcodes::Op1_select_t    Op1Sel;
   opcodes::Op2_select_t    Op2Sel;
   opcodes::Imm_select_t    ImmSel;
   opcodes::Wd_select_t     WdSel;
   opcodes::pc_select_t     PcSel;
   opcodes::Rs1_select_t    Rs1Sel;
   opcodes::Lr_select_t     LrSel;
   logic AluEn;    // Qualifies the ALU function
   logic AluWe;
   logic RegWe;
   logic PcWe;
   logic PcEn;     // PC onto the bus
   logic IrWe;
   logic LrWe;
   logic MemEn;    // Capture SysBusIn
   logic CFlag;
   logic [7:0] OpcodeCondIn;   // IR bits 15:8
   logic [3:0] Flags;

   modport control (
      output AluOp, Op1Sel, Op2Sel, ImmSel, WdSel, PcSel, Rs1Sel, LrSel,
      output AluEn, AluWe, RegWe, PcWe, PcEn, IrWe, LrWe, MemEn, CFlag,
      input  OpcodeCondIn, Flags
   );

   modport datapath (
      input  AluOp, Op1Sel, Op2Sel, ImmSel, WdSel, PcSel, Rs1Sel, LrSel,
      input  AluEn, AluWe, RegWe, PcWe, PcEn, IrWe, LrWe, MemEn, CFlag,
      output OpcodeCondIn, Flags
   );
endinterface

// ==== verilog/control.sv ====
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module control (
   ctrlBus.control Ctrl,
   output logic    ALE,
   output logic    nME,
   output logic    nOE,
   output logic    nWE,
   output logic    ENB,
   input  logic    Clock,
   input  logic    nReset
);

   typedef enum logic {Fetch, Execute} majorState_t;
   typedef enum logic [1:0] {Fet1, Fet2, Fet3, Fet4} fetchState_t;
   typedef enum logic [2:0] {Exe1, Exe2, Exe3, Exe4, Exe5} execState_t;

   majorState_t      State;
   fetchState_t      FetchSub;
   execState_t       ExecuteSub;
   opcodes::Opcode_t Opcode;
   logic [3:0]       StatusReg;
   logic             StatusRegWe;
   logic             IsLongOp;

   assign Opcode = opcodes::Opcode_t'(Ctrl.OpcodeCondIn[7:3]);
   assign IsLongOp = (Opcode == opcodes::LDW) || (Opcode == opcodes::STW) ||
                     (Opcode == opcodes::JMP);

   // Flags from arithmetic ops and compares
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         StatusReg <= '0;
      else if (StatusRegWe)
         StatusReg <= Ctrl.Flags;
   end

   assign Ctrl.CFlag = StatusReg[`FLAGS_C];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State      <= Fetch;
         FetchSub   <= Fet1;
         ExecuteSub <= Exe1;
      end else if (State == Fetch) begin
         case (FetchSub)
            Fet1: FetchSub <= Fet2;
            Fet2: FetchSub <= Fet3;
            Fet3: FetchSub <= Fet4;
            default: begin
               State      <= Execute;
               FetchSub   <= Fet1;
               ExecuteSub <= Exe1;
            end
         endcase
      end else begin
         case (ExecuteSub)
            Exe1: begin
               if (IsLongOp)
                  ExecuteSub <= Exe2;
               else
                  State <= Fetch;   // Single cycle ops
            end
            Exe2: begin
               if (Opcode == opcodes::JMP)
                  State <= Fetch;
               else
                  ExecuteSub <= Exe3;
            end
            Exe3: ExecuteSub <= Exe4;
            Exe4: ExecuteSub <= Exe5;
            default: State <= Fetch;
         endcase
      end
   end

   always_comb begin
      Ctrl.AluOp  = opcodes::FnNOP;
      Ctrl.Op1Sel = opcodes::Op1Rd1;
      Ctrl.Op2Sel = opcodes::Op2Imm;
      Ctrl.ImmSel = opcodes::ImmShort;
      Ctrl.WdSel  = opcodes::WdAlu;
      Ctrl.PcSel  = opcodes::Pc1;
      Ctrl.Rs1Sel = opcodes::Rs1Ra;
      Ctrl.LrSel  = opcodes::LrSys;
      Ctrl.AluEn  = 1'b0;
      Ctrl.AluWe  = 1'b0;
      Ctrl.RegWe  = 1'b0;
      Ctrl.PcWe   = 1'b0;
      Ctrl.PcEn   = 1'b0;
      Ctrl.IrWe   = 1'b0;
      Ctrl.LrWe   = 1'b0;
      Ctrl.MemEn  = 1'b0;
      StatusRegWe = 1'b0;
      ALE = 1'b0;
      nME = 1'b1;   // Strobes idle high
      nOE = 1'b1;
      nWE = 1'b1;
      ENB = 1'b0;
      if (State == Fetch) begin
         case (FetchSub)
            Fet1: begin
               ALE       = 1'b1;   // PC out as address
               Ctrl.PcEn = 1'b1;
            end
            Fet2: begin
               nME = 1'b0;
               nOE = 1'b0;
            end
            Fet3: begin
               nME        = 1'b0;
               nOE        = 1'b0;
               ENB        = 1'b1;
               Ctrl.MemEn = 1'b1;   // Instruction word latched here
            end
            default: Ctrl.IrWe = 1'b1;
         endcase
      end else begin
         case (ExecuteSub)
            Exe1: begin
               case (Opcode)
                  opcodes::ADD, opcodes::ADDI, opcodes::ADDIB, opcodes::ADC,
                  opcodes::ADCI, opcodes::SUB, opcodes::SUBI, opcodes::SUBIB,
                  opcodes::SUC, opcodes::SUCI, opcodes::CMP, opcodes::CMPI: begin
                     Ctrl.AluEn  = 1'b1;
                     Ctrl.PcWe   = 1'b1;
                     StatusRegWe = 1'b1;
                     Ctrl.RegWe  = (Opcode != opcodes::CMP) && (Opcode != opcodes::CMPI);
                     case (Opcode)
                        opcodes::ADD, opcodes::ADDI, opcodes::ADDIB:
                           Ctrl.AluOp = opcodes::FnADD;
                        opcodes::ADC, opcodes::ADCI:
                           Ctrl.AluOp = opcodes::FnADC;
                        opcodes::SUC, opcodes::SUCI:
                           Ctrl.AluOp = opcodes::FnSBC;
                        default:
                           Ctrl.AluOp = opcodes::FnSUB;
                     endcase
                     if (Opcode == opcodes::ADD || Opcode == opcodes::ADC ||
                         Opcode == opcodes::SUB || Opcode == opcodes::SUC ||
                         Opcode == opcodes::CMP)
                        Ctrl.Op2Sel = opcodes::Op2Rd2;   // Register form
                     if (Opcode == opcodes::ADDIB || Opcode == opcodes::SUBIB) begin
                        Ctrl.Rs1Sel = opcodes::Rs1Rd;    // rd op byte
                        Ctrl.ImmSel = opcodes::ImmLong;
                     end
                  end
                  opcodes::LUI, opcodes::LLI: begin
                     Ctrl.AluOp  = opcodes::FnB;
                     Ctrl.AluEn  = 1'b1;
                     Ctrl.ImmSel = (Opcode == opcodes::LUI) ? opcodes::ImmUpper
                                                            : opcodes::ImmLong;
                     Ctrl.RegWe  = 1'b1;
                     Ctrl.PcWe   = 1'b1;
                  end
                  opcodes::LDW, opcodes::STW, opcodes::JMP: begin
                     Ctrl.AluOp = opcodes::FnADD;   // ra plus short immediate
                     Ctrl.AluEn = 1'b1;
                     Ctrl.AluWe = 1'b1;
                  end
                  opcodes::RET: begin
                     Ctrl.PcSel = opcodes::PcLr;
                     Ctrl.PcWe  = 1'b1;
                  end
                  default: Ctrl.PcWe = 1'b1;   // Skip unkept opcodes
               endcase
            end
            Exe2: begin
               if (Opcode == opcodes::JMP) begin
                  Ctrl.PcSel = opcodes::PcAlu;
                  Ctrl.PcWe  = 1'b1;
                  Ctrl.LrWe  = 1'b1;   // Return address
               end else begin
                  ALE = 1'b1;          // Data address from AluReg
               end
            end
            Exe3: begin
               if (Opcode == opcodes::LDW) begin
                  nME = 1'b0;
                  nOE = 1'b0;
               end else begin
                  Ctrl.Rs1Sel = opcodes::Rs1Rd;   // Store data into AluReg
                  Ctrl.AluOp  = opcodes::FnA;
                  Ctrl.AluEn  = 1'b1;
                  Ctrl.AluWe  = 1'b1;
               end
            end
            Exe4: begin
               if (Opcode == opcodes::LDW) begin
                  nME        = 1'b0;
                  nOE        = 1'b0;
                  ENB        = 1'b1;
                  Ctrl.MemEn = 1'b1;
               end else begin
                  nWE = 1'b0;   // Single write cycle
               end
            end
            default: begin
               Ctrl.PcWe = 1'b1;
               if (Opcode == opcodes::LDW) begin
                  Ctrl.WdSel = opcodes::WdSys;
                  Ctrl.RegWe = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module aluUnit (
   input  opcodes::alu_functions_t AluOp,
   input  opcodes::word_t          OpA,
   input  opcodes::word_t          OpB,
   input  logic                    CarryIn,
   output opcodes::word_t          Result,
   output logic [3:0]              Flags
);

   opcodes::word_t           AddB;      // Inverted for subtract
   logic                     AddCin;
   logic                     IsArith;
   logic [`CPU_DATA_WIDTH:0] Sum;

   always_comb begin
      AddB    = OpB;
      AddCin  = 1'b0;
      IsArith = 1'b1;
      case (AluOp)
         opcodes::FnADD: AddCin = 1'b0;
         opcodes::FnADC: AddCin = CarryIn;
         opcodes::FnSUB: begin
            AddB   = ~OpB;
            AddCin = 1'b1;
         end
         opcodes::FnSBC: begin
            AddB   = ~OpB;
            AddCin = CarryIn;   // Carry clear borrows one
         end
         default: IsArith = 1'b0;
      endcase
      Sum = {1'b0, OpA} + {1'b0, AddB} + AddCin;
      case (AluOp)
         opcodes::FnA:   Result = OpA;
         opcodes::FnB:   Result = OpB;
         opcodes::FnNOP: Result = '0;
         default:        Result = Sum[`CPU_DATA_WIDTH-1:0];
      endcase
   end

   assign Flags[`FLAGS_C] = IsArith & Sum[`CPU_DATA_WIDTH];
   assign Flags[`FLAGS_Z] = (Result == '0);
   assign Flags[`FLAGS_N] = Result[`CPU_DATA_WIDTH-1];
   // Same input signs, different result sign
   assign Flags[`FLAGS_V] = IsArith & (OpA[`CPU_DATA_WIDTH-1] == AddB[`CPU_DATA_WIDTH-1]) &
                            (Sum[`CPU_DATA_WIDTH-1] != OpA[`CPU_DATA_WIDTH-1]);

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module registerFile (
   input  logic           Clock,
   input  logic           nReset,
   input  logic [2:0]     ReadAddr1,
   input  logic [2:0]     ReadAddr2,
   input  logic [2:0]     WriteAddr,
   input  logic           WriteEn,
   input  opcodes::word_t WriteData,
   output opcodes::word_t ReadData1,
   output opcodes::word_t ReadData2
);

   opcodes::word_t Regs [`CPU_REG_COUNT];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++)
            Regs[i] <= '0;
      end else if (WriteEn) begin
         Regs[WriteAddr] <= WriteData;
      end
   end

   // Asynchronous read ports
   assign ReadData1 = Regs[ReadAddr1];
   assign ReadData2 = Regs[ReadAddr2];

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module datapath (
   ctrlBus.datapath       Ctrl,
   input  opcodes::word_t SysBusIn,
   output opcodes::word_t SysBusOut,
   input  logic           Clock,
   input  logic           nReset
);

   opcodes::word_t          Pc;
   opcodes::word_t          PcPlus1;
   opcodes::word_t          Ir;
   opcodes::word_t          Lr;
   opcodes::word_t          AluReg;
   opcodes::word_t          DataIn;       // Word captured from the bus
   opcodes::word_t          Imm;
   opcodes::word_t          OpA;
   opcodes::word_t          OpB;
   opcodes::word_t          AluResult;
   opcodes::word_t          ReadData1;
   opcodes::word_t          ReadData2;
   opcodes::word_t          WriteData;
   opcodes::alu_functions_t AluFunc;
   logic [2:0]              ReadAddr1;
   logic [3:0]              AluFlags;

   assign PcPlus1 = Pc + 1'b1;
   assign Ctrl.OpcodeCondIn = Ir[15:8];
   assign Ctrl.Flags = AluFlags;

   always_comb begin
      case (Ctrl.ImmSel)
         opcodes::ImmLong:  Imm = {{(`CPU_DATA_WIDTH-8){1'b0}}, Ir[7:0]};
         opcodes::ImmUpper: Imm = {Ir[7:0], {(`CPU_DATA_WIDTH-8){1'b0}}};
         default:           Imm = {{(`CPU_DATA_WIDTH-5){Ir[4]}}, Ir[4:0]};
      endcase
   end

   assign ReadAddr1 = (Ctrl.Rs1Sel == opcodes::Rs1Rd) ? Ir[10:8] : Ir[7:5];
   assign OpA = (Ctrl.Op1Sel == opcodes::Op1Rd1) ? ReadData1 : '0;
   assign OpB = (Ctrl.Op2Sel == opcodes::Op2Rd2) ? ReadData2 : Imm;
   assign AluFunc = Ctrl.AluEn ? Ctrl.AluOp : opcodes::FnNOP;
   assign WriteData = (Ctrl.WdSel == opcodes::WdSys) ? DataIn : AluResult;

   registerFile uRegs (
      .Clock     (Clock),
      .nReset    (nReset),
      .ReadAddr1 (ReadAddr1),
      .ReadAddr2 (Ir[4:2]),     // rb
      .WriteAddr (Ir[10:8]),    // rd
      .WriteEn   (Ctrl.RegWe),
      .WriteData (WriteData),
      .ReadData1 (ReadData1),
      .ReadData2 (ReadData2)
   );

   aluUnit uAlu (
      .AluOp   (AluFunc),
      .OpA     (OpA),
      .OpB     (OpB),
      .CarryIn (Ctrl.CFlag),
      .Result  (AluResult),
      .Flags   (AluFlags)
   );

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         Pc <= `RESET_PC;
      else if (Ctrl.PcWe)
         case (Ctrl.PcSel)
            opcodes::PcAlu: Pc <= AluReg;   // Jump target
            opcodes::PcLr:  Pc <= Lr;
            default:        Pc <= PcPlus1;
         endcase
   end

   always_ff @(posedge Clock) begin
      if (Ctrl.MemEn)
         DataIn <= SysBusIn;
      if (Ctrl.IrWe)
         Ir <= DataIn;
      if (Ctrl.AluWe)
         AluReg <= AluResult;
      if (Ctrl.LrWe && Ctrl.LrSel == opcodes::LrSys)
         Lr <= PcPlus1;
   end

   assign SysBusOut = Ctrl.PcEn ? Pc : AluReg;

endmodule

// ==== verilog/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
   input  logic           Clock,
   input  logic           nReset,
   input  opcodes::word_t SysBusIn,
   output opcodes::word_t SysBusOut,
   output logic           ALE,
   output logic           nME,
   output logic           nOE,
   output logic           nWE,
   output logic           ENB,
   output logic           CFlag
);

   ctrlBus ctrlIf ();

   control uControl (
      .Ctrl   (ctrlIf.control),
      .ALE    (ALE),
      .nME    (nME),
      .nOE    (nOE),
      .nWE    (nWE),
      .ENB    (ENB),
      .Clock  (Clock),
      .nReset (nReset)
   );

   datapath uDatapath (
      .Ctrl      (ctrlIf.datapath),
      .SysBusIn  (SysBusIn),
      .SysBusOut (SysBusOut),
      .Clock     (Clock),
      .nReset    (nReset)
   );

   assign CFlag = ctrlIf.CFlag;   // Carry from the status register

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
   output logic Clock,
   output logic nReset
);

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;   // 4 ns period
   end

   initial begin
      nReset = 1'b0;
      repeat (8) @(posedge Clock);
      @(negedge Clock);
      nReset <= 1'b1;   // Released on a falling edge
   end

endmodule

// ==== dv/cpuCore_tb.sv ====
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module cpuCore_tb;

   logic             Clock;
   logic             nReset;
   opcodes::word_t   SysBusIn;
   opcodes::word_t   SysBusOut;
   logic             ALE;
   logic             nME;
   logic             nOE;
   logic             nWE;
   logic             ENB;
   logic             CFlag;

   opcodes::word_t   DutMem [256];
   opcodes::word_t   ModelMem [256];
   opcodes::word_t   ModelRegs [`CPU_REG_COUNT];
   opcodes::word_t   ModelPc;
   opcodes::word_t   ModelLr;
   logic             ModelC;
   logic [7:0]       BusAddr;
   opcodes::word_t   PcQ [$];          // Expected fetch addresses
   logic             CarryQ [$];       // Expected CFlag at each fetch
   opcodes::Opcode_t OpQ [$];
   int               TestQ [$];
   opcodes::word_t   StoreAddrQ [$];
   opcodes::word_t   StoreDataQ [$];
   string            TestNames [8];
   int               TestErrors [8];
   int               CurTest = 0;
   int               Checks = 0;
   int               Errors = 0;
   int               Cycles = 0;
   int               CycleLimit = 100;

   clockGen clkGen0 (
      .Clock  (Clock),
      .nReset (nReset)
   );

   cpuCore dut0 (
      .Clock     (Clock),
      .nReset    (nReset),
      .SysBusIn  (SysBusIn),
      .SysBusOut (SysBusOut),
      .ALE       (ALE),
      .nME       (nME),
      .nOE       (nOE),
      .nWE       (nWE),
      .ENB       (ENB),
      .CFlag     (CFlag)
   );

   // Memory model works mid-cycle where the strobes are stable
   always @(negedge Clock) begin
      if (ALE === 1'b1)
         BusAddr <= SysBusOut[7:0];
      if (nWE === 1'b0 && nME === 1'b1)
         DutMem[BusAddr] <= SysBusOut;
      if (ENB === 1'b1 && (nOE !== 1'b0 || nME !== 1'b0))
         reportFailure("data enable outside a read cycle");
      if (nOE === 1'b0 && nME === 1'b0 && ENB === 1'b1)
         SysBusIn <= DutMem[BusAddr];   // Word valid in the data phase only
   end

   always @(posedge Clock) begin
      Cycles <= Cycles + 1;
      if (Cycles > CycleLimit) begin
         $display("Timeout after %0d cycles, the program did not run to its end", Cycles);
         $display("Something failed");
         $finish;
      end
   end

   function automatic opcodes::word_t sext5(input logic [4:0] Imm);
      return {{(`CPU_DATA_WIDTH-5){Imm[4]}}, Imm};
   endfunction

   function automatic logic [`CPU_DATA_WIDTH:0] addWide(input opcodes::word_t X,
                                                        input opcodes::word_t Y,
                                                        input logic Cin);
      return {1'b0, X} + {1'b0, Y} + Cin;
   endfunction

   // Top bit is the carry, set when nothing was borrowed
   function automatic logic [`CPU_DATA_WIDTH:0] subWide(input opcodes::word_t X,
                                                        input opcodes::word_t Y,
                                                        input logic Borrow);
      logic [`CPU_DATA_WIDTH:0] D;
      D = {1'b0, X} - {1'b0, Y} - Borrow;
      return {~D[`CPU_DATA_WIDTH], D[`CPU_DATA_WIDTH-1:0]};
   endfunction

   function automatic opcodes::word_t encReg(input opcodes::Opcode_t Op,
                                             input logic [2:0] Rd, Ra, Rb);
      return {Op, Rd, Ra, Rb, 2'b00};
   endfunction

   function automatic opcodes::word_t encImm(input opcodes::Opcode_t Op,
                                             input logic [2:0] Rd, Ra,
                                             input logic [4:0] Imm);
      return {Op, Rd, Ra, Imm};
   endfunction

   function automatic opcodes::word_t encByte(input opcodes::Opcode_t Op,
                                              input logic [2:0] Rd,
                                              input logic [7:0] Imm);
      return {Op, Rd, Imm};
   endfunction

   function automatic logic [2:0] randDest();
      logic [2:0] R;
      R = 3'($urandom_range(6));
      return (R == 3'd6) ? 3'd7 : R;   // r6 keeps the result base
   endfunction

   function automatic opcodes::Opcode_t pickOp(input int Test);
      int R;
      R = $urandom_range(2);
      case (Test)
         0: return R[0] ? opcodes::LUI : opcodes::LLI;
         1: return (R == 0) ? opcodes::ADD : (R == 1) ? opcodes::ADDI : opcodes::ADDIB;
         2: return (R == 0) ? opcodes::SUB : (R == 1) ? opcodes::SUBI : opcodes::SUBIB;
         3: return (R == 0) ? opcodes::ADC : opcodes::ADCI;
         4: return (R == 0) ? opcodes::SUC : opcodes::SUCI;
         default: return (R == 0) ? opcodes::CMP : opcodes::CMPI;
      endcase
   endfunction

   // Places one instruction at the model PC and executes it in the model
   task automatic emit(input opcodes::word_t Instr);
      opcodes::Opcode_t         Op;
      opcodes::word_t           A;
      opcodes::word_t           B;
      opcodes::word_t           Simm;
      opcodes::word_t           Addr;
      logic [2:0]               Rd;
      logic [`CPU_DATA_WIDTH:0] Wide;
      logic                     IsArith;
      Op      = opcodes::Opcode_t'(Instr[15:11]);
      Rd      = Instr[10:8];
      A       = ModelRegs[Instr[7:5]];
      B       = ModelRegs[Instr[4:2]];
      Simm    = sext5(Instr[4:0]);
      IsArith = 1'b1;
      PcQ.push_back(ModelPc);
      CarryQ.push_back(ModelC);
      OpQ.push_back(Op);
      TestQ.push_back(CurTest);
      ModelMem[ModelPc[7:0]] = Instr;
      DutMem[ModelPc[7:0]]   = Instr;
      ModelPc = ModelPc + 1'b1;
      case (Op)
         opcodes::ADD:   Wide = addWide(A, B, 1'b0);
         opcodes::ADDI:  Wide = addWide(A, Simm, 1'b0);
         opcodes::ADDIB: Wide = addWide(ModelRegs[Rd], Instr[7:0], 1'b0);
         opcodes::ADC:   Wide = addWide(A, B, ModelC);
         opcodes::ADCI:  Wide = addWide(A, Simm, ModelC);
         opcodes::SUB:   Wide = subWide(A, B, 1'b0);
         opcodes::SUBI:  Wide = subWide(A, Simm, 1'b0);
         opcodes::SUBIB: Wide = subWide(ModelRegs[Rd], Instr[7:0], 1'b0);
         opcodes::SUC:   Wide = subWide(A, B, ~ModelC);
         opcodes::SUCI:  Wide = subWide(A, Simm, ~ModelC);
         opcodes::CMP:   Wide = subWide(A, B, 1'b0);
         opcodes::CMPI:  Wide = subWide(A, Simm, 1'b0);
         default: begin
            Wide    = '0;
            IsArith = 1'b0;
         end
      endcase
      if (IsArith) begin
         ModelC = Wide[`CPU_DATA_WIDTH];
         if (Op != opcodes::CMP && Op != opcodes::CMPI)   // Compares keep rd
            ModelRegs[Rd] = Wide[`CPU_DATA_WIDTH-1:0];
      end
      case (Op)
         opcodes::LUI: ModelRegs[Rd] = {Instr[7:0], 8'h00};
         opcodes::LLI: ModelRegs[Rd] = {8'h00, Instr[7:0]};
         opcodes::LDW: begin
            Addr = A + Simm;
            ModelRegs[Rd] = ModelMem[Addr[7:0]];
         end
         opcodes::STW: begin
            Addr = A + Simm;
            ModelMem[Addr[7:0]] = ModelRegs[Rd];
            StoreAddrQ.push_back(Addr);
            StoreDataQ.push_back(ModelRegs[Rd]);
         end
         opcodes::JMP: begin
            ModelLr = ModelPc;   // Already the next instruction
            ModelPc = A + Simm;
         end
         opcodes::RET: ModelPc = ModelLr;
         default: ;
      endcase
   endtask

   task automatic emitAlu(input opcodes::Opcode_t Op);
      logic [2:0] Rd;
      Rd = randDest();
      case (Op)
         opcodes::ADD, opcodes::ADC, opcodes::SUB, opcodes::SUC, opcodes::CMP:
            emit(encReg(Op, Rd, 3'($urandom_range(7)), 3'($urandom_range(7))));
         opcodes::ADDIB, opcodes::SUBIB, opcodes::LUI, opcodes::LLI:
            emit(encByte(Op, Rd, 8'($urandom)));
         default:
            emit(encImm(Op, Rd, 3'($urandom_range(7)), 5'($urandom)));
      endcase
   endtask

   // Few nearby addresses so loads often hit earlier stores
   task automatic emitMemory();
      logic [2:0] Base;
      Base = randDest();
      emit(encByte(opcodes::LLI, Base, 8'(8'hC0 + $urandom_range(3))));
      emit(encImm($urandom_range(1) ? opcodes::LDW : opcodes::STW, randDest(), Base,
                  5'($urandom_range(7) - 4)));
   endtask

   task automatic emitCall(input int Slot);
      logic [2:0]     Base;
      logic [4:0]     Off;
      opcodes::word_t Target;
      Base   = randDest();
      Off    = 5'($urandom_range(7) - 4);
      Target = 16'h00A0 + 16'(Slot * 4);   // Subroutine area
      emit(encByte(opcodes::LLI, Base, 8'(Target - sext5(Off))));
      emit(encImm(opcodes::JMP, randDest(), Base, Off));
      emitAlu(pickOp(1));
      emitAlu(pickOp(2));
      emit(encReg(opcodes::RET, 3'd0, 3'd0, 3'd0));
   endtask

   task automatic emitTest(input int Test);
      CurTest = Test;
      emit(encByte(opcodes::LLI, 3'd6, 8'hF0));   // Result area base
      for (int i = 0; i < 8; i++)
         case (Test)
            6: emitMemory();
            7: if (i < 3) emitCall(i);
            default: emitAlu(pickOp(Test));
         endcase
      for (int r = 0; r < `CPU_REG_COUNT; r++)
         emit(encImm(opcodes::STW, 3'(r), 3'd6, 5'(r)));
   endtask

   task automatic reportFailure(input string Msg);
      Errors++;
      TestErrors[CurTest]++;
      $display("Test %s failed: %s", TestNames[CurTest], Msg);
   endtask

   task automatic checkFetch(input opcodes::word_t Expected, input opcodes::word_t Actual);
      Checks++;
      if (Actual !== Expected) begin
         Errors++;
         TestErrors[CurTest]++;
         $display("[ERROR] %s fetch: expected %h, actual %h", TestNames[CurTest],
                  Expected, Actual);
      end
   endtask

   task automatic checkStore(input opcodes::word_t ExpAddr, input opcodes::word_t ExpData,
                             input opcodes::word_t Addr, input opcodes::word_t Data);
      Checks++;
      if (Addr !== ExpAddr || Data !== ExpData) begin
         Errors++;
         TestErrors[CurTest]++;
         $display("[ERROR] %s store: expected %h at %h, actual %h at %h",
                  TestNames[CurTest], ExpData, ExpAddr, Data, Addr);
      end
   endtask

   task automatic checkCarry(input logic Expected, input logic Actual);
      Checks++;
      if (Actual !== Expected) begin
         Errors++;
         TestErrors[CurTest]++;
         $display("[ERROR] %s carry: expected %b, actual %b", TestNames[CurTest],
                  Expected, Actual);
      end
   endtask

   task automatic waitAle(output opcodes::word_t Addr);
      do begin
         @(negedge Clock);
         if (nWE === 1'b0)
            reportFailure("write strobe outside a store instruction");
      end while (ALE !== 1'b1);
      Addr = SysBusOut;
   endtask

   task automatic waitWrite(output opcodes::word_t Data);
      do
         @(negedge Clock);
      while (nWE !== 1'b0 && ALE !== 1'b1);
      if (ALE === 1'b1)
         reportFailure("store ended without a write strobe");
      Data = SysBusOut;
   endtask

   task automatic reportTest(input int Test);
      $display("Test %s done, %0d errors", TestNames[Test], TestErrors[Test]);
   endtask

   initial begin
      int             NumInstr;
      opcodes::word_t Addr;
      opcodes::word_t DataAddr;
      opcodes::word_t Data;
      void'($urandom(90426));
      SysBusIn = '0;
      TestNames = '{"immediate", "add", "subtract", "addCarry", "subBorrow",
                    "compare", "memory", "jumpLink"};
      for (int a = 0; a < 256; a++) begin
         ModelMem[a] = {8'(a), ~8'(a)};   // Fill follows the whole address
         DutMem[a]   = {8'(a), ~8'(a)};
      end
      for (int r = 0; r < `CPU_REG_COUNT; r++)
         ModelRegs[r] = '0;
      ModelPc = `RESET_PC;
      ModelLr = '0;
      ModelC  = 1'b0;
      for (int t = 0; t < 8; t++) begin
         TestErrors[t] = 0;
         emitTest(t);
      end
      PcQ.push_back(ModelPc);   // Fetch after the last store
      CarryQ.push_back(ModelC);
      NumInstr   = OpQ.size();
      CycleLimit = (NumInstr + 1) * 9 + 100;
      CurTest    = 0;

      wait (nReset === 1'b1);
      if (ALE !== 1'b1)
         reportFailure("no address strobe in the first cycle after reset");
      Addr = SysBusOut;
      for (int i = 0; i <= NumInstr; i++) begin
         if (i > 0)
            waitAle(Addr);
         checkCarry(CarryQ[i], CFlag);
         checkFetch(PcQ[i], Addr);
         if (i == NumInstr) begin
            reportTest(CurTest);
         end else begin
            if (i > 0 && TestQ[i] != CurTest)
               reportTest(CurTest);
            CurTest = TestQ[i];
            if (OpQ[i] == opcodes::LDW || OpQ[i] == opcodes::STW) begin
               waitAle(DataAddr);
               if (OpQ[i] == opcodes::STW) begin
                  waitWrite(Data);
                  checkStore(StoreAddrQ.pop_front(), StoreDataQ.pop_front(), DataAddr, Data);
               end
            end
         end
      end

      $display("Checks: %0d, errors: %0d", Checks, Errors);
      if (Errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== cpuCore.f ====
+incdir+include
verilog/opcodes.sv
verilog/ctrlBus.sv
verilog/control.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/datapath.sv
verilog/cpuCore.sv
dv/clockGen.sv
dv/cpuCore_tb.sv

// ==== Bender.yml ====
package:
  name: cpuCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/opcodes.sv
      - verilog/ctrlBus.sv
      - verilog/control.sv
      - verilog/aluUnit.sv
      - verilog/registerFile.sv
      - verilog/datapath.sv
      - verilog/cpuCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/clockGen.sv
      - dv/cpuCore_tb.sv
